// ==== hw/sched_cfg_pkg.sv ====
package sched_cfg_pkg;

  // Default number of flows in the scheduler
  localparam int unsigned NUM_FLOWS = 4;

  // Default entries per flow FIFO
  localparam int unsigned QUEUE_DEPTH = 4;

  // Flow number width, at least one bit
  localparam int unsigned FLOW_W = (NUM_FLOWS > 1) ? $clog2(NUM_FLOWS) : 1;

  // Weight is the per-cycle virtual time increment
  localparam int unsigned WEIGHT_W = 4;

  // Virtual time counters wrap at this width
  localparam int unsigned TIME_W = 16;

  // Flow number or arbitrated index
  typedef logic [FLOW_W-1:0] flow_id_t;
  // Per-flow weight
  typedef logic [WEIGHT_W-1:0] weight_t;
  // Virtual time value
  typedef logic [TIME_W-1:0] vtime_t;

endpackage

// ==== hw/flow_pkg.sv ====
package flow_pkg;

  // Flow numbers come from the config package
  import sched_cfg_pkg::*;

  // Payload width of one packet
  localparam int unsigned PAYLOAD_W = 12;

  // Packet payload
  typedef logic [PAYLOAD_W-1:0] payload_t;

  // Packet descriptor on the enqueue and dequeue ports
  // On dequeue the flow field names the source flow
  typedef struct packed {
    flow_id_t flow;
    payload_t payload;
  } pkt_desc_t;

endpackage

// ==== hw/min_max_tree.sv ====
`timescale 1ns/1ps

module min_max_tree #(
  parameter int unsigned NumIn     = 4,
  parameter int unsigned DataWidth = 16
) (
  input  logic [NumIn-1:0][DataWidth-1:0]          data_i,
  input  logic [NumIn-1:0]                         valid_i,
  input  logic                                     is_max_i,
  output logic [DataWidth-1:0]                     data_o,
  output logic                                     valid_o,
  output logic [((NumIn > 1) ? $clog2(NumIn) : 1)-1:0] idx_o
);

  // Index width, at least one bit
  localparam int unsigned IdxWidth  = (NumIn > 1) ? $clog2(NumIn) : 1;
  // Leaves padded up to a power of two
  localparam int unsigned NumLevels = (NumIn > 1) ? $clog2(NumIn) : 0;
  localparam int unsigned NumLeaves = 2 ** NumLevels;
  // Heap layout: node n has children 2n+1 and 2n+2, root at 0
  localparam int unsigned NumNodes  = 2 * NumLeaves - 1;

  logic [DataWidth-1:0] node_data  [NumNodes];
  logic                 node_valid [NumNodes];
  logic [IdxWidth-1:0]  node_idx   [NumNodes];

  // Leaves sit at the end of the heap
  for (genvar l = 0; l < NumLeaves; l++) begin : g_leaf
    if (l < NumIn) begin : g_used
      assign node_data[NumLeaves-1+l]  = data_i[l];
      assign node_valid[NumLeaves-1+l] = valid_i[l];
      assign node_idx[NumLeaves-1+l]   = IdxWidth'(l);
    end else begin : g_pad
      // Padding leaves never win
      assign node_data[NumLeaves-1+l]  = '0;
      assign node_valid[NumLeaves-1+l] = 1'b0;
      assign node_idx[NumLeaves-1+l]   = '0;
    end
  end

  // Compare-select nodes
  for (genvar n = 0; n < NumLeaves - 1; n++) begin : g_node
    logic cmp_left;
    logic sel_left;

    // Left subtree holds lower indices, so equality favours it
    assign cmp_left = is_max_i ? (node_data[2*n+1] >= node_data[2*n+2])
                               : (node_data[2*n+1] <= node_data[2*n+2]);

    // A valid operand always beats an invalid one
    assign sel_left = node_valid[2*n+1] & (~node_valid[2*n+2] | cmp_left);

    assign node_data[n]  = sel_left ? node_data[2*n+1] : node_data[2*n+2];
    assign node_idx[n]   = sel_left ? node_idx[2*n+1]  : node_idx[2*n+2];
    // OR of the children, so the root is the OR of all inputs
    assign node_valid[n] = node_valid[2*n+1] | node_valid[2*n+2];
  end

  // Root carries the result
  assign data_o  = node_data[0];
  assign valid_o = node_valid[0];
  assign idx_o   = node_idx[0];

endmodule

// ==== hw/bvt_arb_tree.sv ====
`timescale 1ns/1ps

module bvt_arb_tree import sched_cfg_pkg::*, flow_pkg::*; #(
  parameter int unsigned NumIn     = 4,
  parameter int unsigned TimeWidth = 16
) (
  input  logic                     clk_i,
  input  logic                     reset_i,
  input  weight_t  [NumIn-1:0]     prio_i,
  input  logic     [NumIn-1:0]     req_i,
  output logic     [NumIn-1:0]     gnt_o,
  input  payload_t [NumIn-1:0]     data_i,
  output logic                     req_o,
  input  logic                     gnt_i,
  output payload_t                 data_o,
  output flow_id_t                 idx_o
);

  // Width of the tree index
  localparam int unsigned IdxWidth = (NumIn > 1) ? $clog2(NumIn) : 1;

  // One virtual time counter per input
  logic [NumIn-1:0][TimeWidth-1:0] vtime_d, vtime_q;

  // Winning input from the tree
  logic [IdxWidth-1:0] win_idx;
  logic                handshake;

  // Smallest counter among the requesters, ties to the lower index
  min_max_tree #(
    .NumIn     (NumIn),
    .DataWidth (TimeWidth)
  ) i_min_tree (
    .data_i   (vtime_q),
    .valid_i  (req_i),
    .is_max_i (1'b0),
    .data_o   (),
    .valid_o  (req_o),
    .idx_o    (win_idx)
  );

  // Transfer happens when a request is offered and accepted
  assign handshake = req_o & gnt_i;

  // Next counters
  always_comb begin
    // Every counter grows by its weight, requesting or not
    for (int i = 0; i < NumIn; i++) begin
      vtime_d[i] = vtime_q[i] + TimeWidth'(prio_i[i]);
    end
    // Granted flow restarts from zero
    if (handshake) begin
      vtime_d[win_idx] = '0;
    end
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      vtime_q <= '0;
    end else begin
      vtime_q <= vtime_d;
    end
  end

  // One-hot grant back to the winner only
  always_comb begin
    gnt_o          = '0;
    gnt_o[win_idx] = handshake;
  end

  // Winner's data and index
  assign data_o = data_i[win_idx];
  assign idx_o  = flow_id_t'(win_idx);

endmodule

// ==== hw/flow_queue.sv ====
`timescale 1ns/1ps

module flow_queue import flow_pkg::*; #(
  parameter int unsigned Depth = 4
) (
  input  logic     clk_i,
  input  logic     reset_i,
  input  logic     push_i,
  input  payload_t data_i,
  input  logic     pop_i,
  output payload_t data_o,
  output logic     empty_o,
  output logic     full_o
);

  // Pointer and fill count widths
  localparam int unsigned PtrWidth = (Depth > 1) ? $clog2(Depth) : 1;
  localparam int unsigned CntWidth = $clog2(Depth + 1);

  // Payload storage
  payload_t mem [Depth];

  logic [PtrWidth-1:0] wr_ptr_q, rd_ptr_q;
  logic [CntWidth-1:0] count_q;
  logic                do_push, do_pop;

  assign empty_o = (count_q == '0);
  assign full_o  = (count_q == CntWidth'(Depth));

  // Push while full drops the packet
  assign do_push = push_i & ~full_o;
  // Pop of an empty queue does nothing
  assign do_pop  = pop_i & ~empty_o;

  // Storage write
  always_ff @(posedge clk_i) begin
    if (do_push) begin
      mem[wr_ptr_q] <= data_i;
    end
  end

  // Pointers wrap at Depth, which need not be a power of two
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (do_push) begin
        wr_ptr_q <= (wr_ptr_q == PtrWidth'(Depth - 1)) ? '0 : wr_ptr_q + 1'b1;
      end
      if (do_pop) begin
        rd_ptr_q <= (rd_ptr_q == PtrWidth'(Depth - 1)) ? '0 : rd_ptr_q + 1'b1;
      end
      // Simultaneous push and pop leave the count unchanged
      if (do_push && !do_pop) begin
        count_q <= count_q + 1'b1;
      end else if (do_pop && !do_push) begin
        count_q <= count_q - 1'b1;
      end
    end
  end

  // Head entry, zero while empty
  assign data_o = empty_o ? '0 : mem[rd_ptr_q];

endmodule

// ==== hw/bvt_sched_top.sv ====
`timescale 1ns/1ps

module bvt_sched_top import sched_cfg_pkg::*, flow_pkg::*; #(
  parameter int unsigned NumFlows   = NUM_FLOWS,
  parameter int unsigned QueueDepth = QUEUE_DEPTH,
  parameter int unsigned TimeWidth  = TIME_W
) (
  input  logic                   clk_i,
  input  logic                   reset_i,
  input  logic                   enq_valid_i,
  input  pkt_desc_t              enq_pkt_i,
  input  weight_t [NumFlows-1:0] weights_i,
  output logic                   deq_valid_o,
  input  logic                   deq_ready_i,
  output pkt_desc_t              deq_pkt_o,
  output logic    [NumFlows-1:0] full_o
);

  // Per-flow queue signals
  logic     [NumFlows-1:0] push;
  logic     [NumFlows-1:0] pop;
  logic     [NumFlows-1:0] empty;
  payload_t [NumFlows-1:0] head;

  // Arbiter result
  payload_t win_payload;
  flow_id_t win_flow;

  for (genvar f = 0; f < NumFlows; f++) begin : g_flow
    // Route by the flow field of the descriptor
    assign push[f] = enq_valid_i & (enq_pkt_i.flow == flow_id_t'(f));

    flow_queue #(
      .Depth (QueueDepth)
    ) i_queue (
      .clk_i   (clk_i),
      .reset_i (reset_i),
      .push_i  (push[f]),
      .data_i  (enq_pkt_i.payload),
      .pop_i   (pop[f]),
      .data_o  (head[f]),
      .empty_o (empty[f]),
      .full_o  (full_o[f])
    );
  end

  // Non-empty queues request, output ready acts as the grant
  bvt_arb_tree #(
    .NumIn     (NumFlows),
    .TimeWidth (TimeWidth)
  ) i_arb (
    .clk_i   (clk_i),
    .reset_i (reset_i),
    .prio_i  (weights_i),
    .req_i   (~empty),
    .gnt_o   (pop),
    .data_i  (head),
    .req_o   (deq_valid_o),
    .gnt_i   (deq_ready_i),
    .data_o  (win_payload),
    .idx_o   (win_flow)
  );

  // Output descriptor tagged with the source flow
  assign deq_pkt_o.flow    = win_flow;
  assign deq_pkt_o.payload = win_payload;

endmodule

// ==== include/bvt_ref_model.svh ====
`ifndef BVT_REF_MODEL_SVH
`define BVT_REF_MODEL_SVH

// Expected winner among the non-empty flows, -1 when all are empty
// The smallest virtual time wins
// A higher flow number needs a strictly smaller time to take over
function automatic int ref_winner(
  input logic [NUM_FLOWS-1:0]             nonempty,
  input logic [NUM_FLOWS-1:0][TIME_W-1:0] times
);
  int best;
  best = -1;
  for (int f = 0; f < NUM_FLOWS; f++) begin
    if (nonempty[f]) begin
      if (best < 0) begin
        best = f;
      end else if (times[f] < times[best]) begin
        best = f;
      end
    end
  end
  return best;
endfunction

// Counters after one rising edge
// Every flow is charged its weight, the served flow restarts at zero
function automatic logic [NUM_FLOWS-1:0][TIME_W-1:0] ref_next_times(
  input logic [NUM_FLOWS-1:0][TIME_W-1:0]   times,
  input logic [NUM_FLOWS-1:0][WEIGHT_W-1:0] weights,
  input logic                               transfer,
  input int                                 winner
);
  logic [NUM_FLOWS-1:0][TIME_W-1:0] next;
  for (int f = 0; f < NUM_FLOWS; f++) begin
    // Wraps at TIME_W bits like the hardware counters
    next[f] = times[f] + TIME_W'(weights[f]);
  end
  if (transfer && winner >= 0) begin
    next[winner] = '0;
  end
  return next;
endfunction

`endif

// ==== bench/bvt_sched_tb.sv ====
`timescale 1ns/1ps

module bvt_sched_tb
  import sched_cfg_pkg::*, flow_pkg::*;
();

  // Upper bound on cycles for any drain wait
  localparam int DRAIN_LIMIT = 2000;

  logic                   clk_i;
  logic                   reset_i;
  logic                   enq_valid_i;
  pkt_desc_t              enq_pkt_i;
  weight_t [NUM_FLOWS-1:0] weights_i;
  logic                   deq_valid_o;
  logic                   deq_ready_i;
  pkt_desc_t              deq_pkt_o;
  logic    [NUM_FLOWS-1:0] full_o;

  // Model state: one payload queue and one virtual time per flow
  payload_t                         model_q [NUM_FLOWS][$];
  logic [NUM_FLOWS-1:0][TIME_W-1:0] model_time;

  int    error_count = 0;
  int    check_count = 0;
  int    test_count = 0;
  int    test_start_errors = 0;
  string test_name;

  `include "bvt_ref_model.svh"

  bvt_sched_top dut (
    .clk_i       (clk_i),
    .reset_i     (reset_i),
    .enq_valid_i (enq_valid_i),
    .enq_pkt_i   (enq_pkt_i),
    .weights_i   (weights_i),
    .deq_valid_o (deq_valid_o),
    .deq_ready_i (deq_ready_i),
    .deq_pkt_o   (deq_pkt_o),
    .full_o      (full_o)
  );

  initial begin
    clk_i = 1'b0;
    forever #2 clk_i = ~clk_i;
  end

  task automatic check_value(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
    check_count++;
    if (got !== exp) begin
      error_count++;
      $display("ERROR %s: got 0x%0h, expected 0x%0h at %0t", name, got, exp, $time);
    end
  endtask

  // A drain that never completes counts as an error of the running test
  task automatic report_timeout(input string what);
    error_count++;
    $display("Timeout while waiting for %s to drain", what);
  endtask

  // True while any model queue still holds a packet
  function automatic logic model_busy();
    logic busy;
    busy = 1'b0;
    for (int f = 0; f < NUM_FLOWS; f++) begin
      busy |= (model_q[f].size() > 0);
    end
    return busy;
  endfunction

  task automatic start_test(input string name);
    test_name = name;
    test_start_errors = error_count;
    test_count++;
  endtask

  task automatic end_test();
    int errs;
    errs = error_count - test_start_errors;
    $display("Test %0d %s: %s, %0d mismatches", test_count, test_name,
             (errs == 0) ? "PASS" : "FAIL", errs);
  endtask

  // Holds the strobe for one cycle per call, back to back
  task automatic push_packet(input int flow, input int payload);
    @(negedge clk_i);
    enq_valid_i       = 1'b1;
    enq_pkt_i.flow    = flow_id_t'(flow);
    enq_pkt_i.payload = payload_t'(payload);
  endtask

  task automatic end_pushes();
    @(negedge clk_i);
    enq_valid_i = 1'b0;
  endtask

  task automatic wait_drained(input string what);
    int cycles;
    cycles = 0;
    while (model_busy() && cycles < DRAIN_LIMIT) begin
      @(negedge clk_i);
      cycles++;
    end
    if (model_busy()) begin
      report_timeout(what);
    end
  endtask

  // Compare the DUT with the model, then step the model with this edge's inputs
  always @(posedge clk_i) begin : compare_model
    logic [NUM_FLOWS-1:0] nonempty;
    logic [NUM_FLOWS-1:0] full_exp;
    pkt_desc_t            exp_pkt;
    logic                 transfer;
    int                   win;
    if (reset_i) begin
      for (int f = 0; f < NUM_FLOWS; f++) begin
        model_q[f].delete();
      end
      model_time = '0;
    end else begin
      for (int f = 0; f < NUM_FLOWS; f++) begin
        nonempty[f] = (model_q[f].size() > 0);
        full_exp[f] = (model_q[f].size() == QUEUE_DEPTH);
      end
      win = ref_winner(nonempty, model_time);
      check_value("deq_valid_o", deq_valid_o, win >= 0);
      // Packet contents only matter while one is offered
      if (win >= 0) begin
        exp_pkt.flow    = flow_id_t'(win);
        exp_pkt.payload = model_q[win][0];
        check_value("deq_pkt_o", deq_pkt_o, exp_pkt);
      end
      check_value("full_o", full_o, full_exp);
      transfer   = (win >= 0) && deq_ready_i;
      model_time = ref_next_times(model_time, weights_i, transfer, win);
      if (transfer) begin
        void'(model_q[win].pop_front());
      end
      // Drop decision uses the fill level from before this edge's pop
      if (enq_valid_i && !full_exp[enq_pkt_i.flow]) begin
        model_q[enq_pkt_i.flow].push_back(enq_pkt_i.payload);
      end
    end
  end

  initial begin
    int cycles;
    int hold;
    void'($urandom(52812));
    reset_i     = 1'b1;
    enq_valid_i = 1'b0;
    enq_pkt_i   = '0;
    deq_ready_i = 1'b0;
    for (int f = 0; f < NUM_FLOWS; f++) begin
      weights_i[f] = weight_t'(1);
    end
    repeat (5) @(negedge clk_i);
    reset_i = 1'b0;

    // FIFO order within one flow
    start_test("single flow");
    for (int i = 0; i < QUEUE_DEPTH; i++) begin
      push_packet(1, 'h100 + i);
    end
    end_pushes();
    deq_ready_i = 1'b1;
    wait_drained("single flow");
    end_test();

    // Equal weights, ties go to the lowest flow
    start_test("equal weights");
    deq_ready_i = 1'b0;
    for (int f = 0; f < NUM_FLOWS; f++) begin
      weights_i[f] = weight_t'(2);
    end
    for (int i = 0; i < 3; i++) begin
      for (int f = 0; f < NUM_FLOWS; f++) begin
        push_packet(f, 'h200 + 16 * f + i);
      end
    end
    end_pushes();
    deq_ready_i = 1'b1;
    wait_drained("equal weights");
    end_test();

    // Heavier flows age faster and get served later
    start_test("unequal weights");
    deq_ready_i = 1'b0;
    for (int f = 0; f < NUM_FLOWS; f++) begin
      weights_i[f] = weight_t'(1 << f);
    end
    for (int i = 0; i < QUEUE_DEPTH; i++) begin
      for (int f = 0; f < NUM_FLOWS; f++) begin
        push_packet(f, 'h300 + 16 * f + i);
      end
    end
    end_pushes();
    deq_ready_i = 1'b1;
    wait_drained("unequal weights");
    end_test();

    // Ready toggles in random stretches while the queues drain
    start_test("back-pressure");
    deq_ready_i = 1'b0;
    for (int f = 0; f < NUM_FLOWS; f++) begin
      weights_i[f] = weight_t'($urandom_range(1, 15));
    end
    for (int i = 0; i < QUEUE_DEPTH; i++) begin
      for (int f = 0; f < NUM_FLOWS; f++) begin
        push_packet(f, 'h400 + 16 * f + i);
      end
    end
    end_pushes();
    cycles = 0;
    hold   = 0;
    while (model_busy() && cycles < DRAIN_LIMIT) begin
      @(negedge clk_i);
      if (hold == 0) begin
        deq_ready_i = ~deq_ready_i;
        hold        = $urandom_range(1, 6);
      end
      hold--;
      cycles++;
    end
    if (model_busy()) begin
      report_timeout("back-pressure");
    end
    end_test();

    // Extra packets beyond the depth are dropped
    start_test("overflow");
    deq_ready_i = 1'b0;
    for (int i = 0; i < QUEUE_DEPTH + 2; i++) begin
      push_packet(2, 'h500 + i);
    end
    end_pushes();
    check_value("full_o[2]", full_o[2], 1'b1);
    deq_ready_i = 1'b1;
    wait_drained("overflow");
    check_value("full_o", full_o, '0);
    end_test();

    // Random enqueues and ready levels
    start_test("random traffic");
    for (int c = 0; c < 400; c++) begin
      @(negedge clk_i);
      enq_valid_i       = 1'($urandom_range(0, 1));
      enq_pkt_i.flow    = flow_id_t'($urandom_range(0, NUM_FLOWS - 1));
      enq_pkt_i.payload = payload_t'($urandom);
      deq_ready_i       = ($urandom_range(0, 3) != 0);
    end
    end_pushes();
    deq_ready_i = 1'b1;
    wait_drained("random traffic");
    end_test();

    $display("%0d tests, %0d checks, %0d errors", test_count, check_count, error_count);
    if (error_count == 0) begin
      $display("Simulation completed successfully");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

endmodule

// ==== vlog.f ====
+incdir+include
hw/sched_cfg_pkg.sv
hw/flow_pkg.sv
hw/min_max_tree.sv
hw/bvt_arb_tree.sv
hw/flow_queue.sv
hw/bvt_sched_top.sv
bench/bvt_sched_tb.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Build and run the BVT scheduler testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing -Wno-fatal --top-module bvt_sched_tb -f vlog.f

output="$(./obj_dir/Vbvt_sched_tb)"
echo "$output"

if echo "$output" | grep -q "Simulation completed successfully"; then
  exit 0
else
  exit 1
fi
